// File: hdl/dijkstra_consts.svh
`ifndef DIJKSTRA_CONSTS_SVH
`define DIJKSTRA_CONSTS_SVH

// graph capacity
`define MAX_NODES   16
`define MAX_EDGES   24
`define MAX_DEGREE  6      // neighbor slots per node

// one initial push plus at most two pushes per edge
`define HEAP_DEPTH  64

// field widths
`define NODE_W      4
`define WEIGHT_W    4
`define DIST_W      8      // 15 hops of weight 15 still fit
`define SLOT_W      3
`define HEAP_IDX_W  7

`define DIST_INF    255    // reported for unreachable nodes

`endif

// File: hdl/dijkstra_pkg.sv
`include "dijkstra_consts.svh"

package dijkstra_pkg;

    typedef logic [`NODE_W-1:0]     node_t;
    typedef logic [`WEIGHT_W-1:0]   weight_t;
    typedef logic [`DIST_W-1:0]     dist_t;
    typedef logic [`SLOT_W-1:0]     slot_t;      // neighbor slot, also a degree
    typedef logic [`HEAP_IDX_W-1:0] heap_idx_t;  // 1-based heap position

    typedef enum logic [3:0] {
        IDLE,       // waiting for the first edge of a job
        LOAD,       // taking the remaining edges
        INIT,       // distance table reset, source pushed
        POP,
        WAIT_POP,
        CHECK,      // visited test on the popped node
        RELAX,      // one neighbor slot per cycle
        WAIT_PUSH,
        STREAM      // one distance beat per node
    } ctrl_state_t;

endpackage

// File: hdl/adjacency_list.sv
`timescale 1ns/1ps
`include "dijkstra_consts.svh"

module adjacency_list
    import dijkstra_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    clear,
    input  logic    load_en,
    input  node_t   load_src,
    input  node_t   load_dst,
    input  weight_t load_weight,
    input  node_t   rd_node,
    input  slot_t   rd_slot,
    output node_t   rd_neighbor,
    output weight_t rd_weight,
    output slot_t   rd_degree
);

    node_t   nbr_tab [`MAX_NODES][`MAX_DEGREE];
    weight_t wt_tab  [`MAX_NODES][`MAX_DEGREE];
    slot_t   degree  [`MAX_NODES];

    slot_t   src_deg;
    slot_t   dst_deg;

    // a clear in the same cycle as the first edge starts both lists at slot 0
    assign src_deg = clear ? '0 : degree[load_src];
    assign dst_deg = clear ? '0 : degree[load_dst];

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `MAX_NODES; i++) begin
                degree[i] <= '0;
            end
        end else begin
            if (clear) begin
                for (int i = 0; i < `MAX_NODES; i++) begin
                    degree[i] <= '0;
                end
            end
            if (load_en) begin
                degree[load_src] <= src_deg + 1'b1;
                degree[load_dst] <= dst_deg + 1'b1;
            end
        end
    end

    // undirected edge, stored once in each endpoint's list
    always_ff @(posedge clk) begin
        if (load_en) begin
            nbr_tab[load_src][src_deg] <= load_dst;
            wt_tab[load_src][src_deg]  <= load_weight;
            nbr_tab[load_dst][dst_deg] <= load_src;
            wt_tab[load_dst][dst_deg]  <= load_weight;
        end
    end

    assign rd_neighbor = nbr_tab[rd_node][rd_slot];
    assign rd_weight   = wt_tab[rd_node][rd_slot];
    assign rd_degree   = degree[rd_node];

    a_degree_limit: assert property (@(posedge clk) disable iff (!reset)
        load_en |-> (src_deg < `MAX_DEGREE) && (dst_deg < `MAX_DEGREE))
        else $error("adjacency list full on node %0d or %0d", load_src, load_dst);

    a_no_self_loop: assert property (@(posedge clk) disable iff (!reset)
        load_en |-> load_src != load_dst)
        else $error("self-loop on node %0d", load_src);

endmodule

// File: hdl/min_heap.sv
`timescale 1ns/1ps
`include "dijkstra_consts.svh"

module min_heap
    import dijkstra_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  clear,
    input  logic  push,
    input  dist_t push_dist,
    input  node_t push_node,
    input  logic  pop,
    output dist_t top_dist,
    output node_t top_node,
    output logic  empty,
    output logic  busy
);

    dist_t     heap_dist [1:`HEAP_DEPTH];
    node_t     heap_node [1:`HEAP_DEPTH];
    heap_idx_t len;
    heap_idx_t idx;                // entry being sifted
    logic      sift_up;

    heap_idx_t  parent_idx;
    heap_idx_t  child_idx;
    logic [7:0] left_idx;          // one bit wider, 2*64 must not wrap
    logic [7:0] right_idx;
    logic       left_ok;
    logic       right_ok;
    logic       up_swap;
    logic       down_swap;
    logic       start_push;
    logic       start_pop;

    assign start_push = !clear && !busy && push;
    assign start_pop  = !clear && !busy && !push && pop;

    assign parent_idx = idx >> 1;
    assign left_idx   = {idx, 1'b0};
    assign right_idx  = {idx, 1'b1};
    assign left_ok    = left_idx <= {1'b0, len};
    assign right_ok   = right_idx <= {1'b0, len};

    always_comb begin
        up_swap   = (idx > 1) && (heap_dist[parent_idx] > heap_dist[idx]);
        child_idx = left_idx[6:0];
        if (right_ok && (heap_dist[right_idx[6:0]] < heap_dist[left_idx[6:0]])) begin
            child_idx = right_idx[6:0];  // smaller child wins
        end
        down_swap = left_ok && (heap_dist[child_idx] < heap_dist[idx]);
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            len     <= '0;
            idx     <= 7'd1;
            sift_up <= 1'b0;
            busy    <= 1'b0;
        end else if (clear) begin
            len  <= '0;
            busy <= 1'b0;
        end else if (start_push) begin
            len     <= len + 1'b1;
            idx     <= len + 1'b1;
            sift_up <= 1'b1;
            busy    <= 1'b1;
        end else if (start_pop) begin
            len     <= len - 1'b1;
            idx     <= 7'd1;
            sift_up <= 1'b0;
            busy    <= 1'b1;
        end else if (busy) begin
            if (sift_up) begin
                if (up_swap) idx <= parent_idx;
                else         busy <= 1'b0;
            end else begin
                if (down_swap) idx <= child_idx;
                else           busy <= 1'b0;
            end
        end
    end

    // entry storage, one level moved per cycle
    always_ff @(posedge clk) begin
        if (start_push) begin
            heap_dist[len + 1'b1] <= push_dist;
            heap_node[len + 1'b1] <= push_node;
        end else if (start_pop) begin
            heap_dist[1] <= heap_dist[len];   // last entry to the root
            heap_node[1] <= heap_node[len];
        end else if (busy && sift_up && up_swap) begin
            heap_dist[idx]        <= heap_dist[parent_idx];
            heap_node[idx]        <= heap_node[parent_idx];
            heap_dist[parent_idx] <= heap_dist[idx];
            heap_node[parent_idx] <= heap_node[idx];
        end else if (busy && !sift_up && down_swap) begin
            heap_dist[idx]       <= heap_dist[child_idx];
            heap_node[idx]       <= heap_node[child_idx];
            heap_dist[child_idx] <= heap_dist[idx];
            heap_node[child_idx] <= heap_node[idx];
        end
    end

    assign top_dist = heap_dist[1];
    assign top_node = heap_node[1];
    assign empty    = (len == '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (!reset)
        start_push |-> len < `HEAP_DEPTH)
        else $error("heap push beyond %0d entries", `HEAP_DEPTH);

    a_no_underflow: assert property (@(posedge clk) disable iff (!reset)
        (pop && !busy && !clear) |-> !empty)
        else $error("heap pop while empty");

    // the controller must wait for a sift to finish before the next request
    a_idle_request: assert property (@(posedge clk) disable iff (!reset)
        (push || pop) |-> !busy)
        else $error("heap request while busy");

endmodule

// File: hdl/dijkstra_ctrl.sv
`timescale 1ns/1ps
`include "dijkstra_consts.svh"

module dijkstra_ctrl
    import dijkstra_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    edge_valid,
    input  node_t   node_count,
    input  node_t   edge_src,
    input  node_t   edge_dst,
    input  weight_t edge_weight,
    input  logic    edge_last,
    input  logic    dist_ready,
    input  node_t   rd_neighbor,
    input  weight_t rd_weight,
    input  slot_t   rd_degree,
    input  dist_t   top_dist,
    input  node_t   top_node,
    input  logic    empty,
    input  logic    busy,
    output logic    edge_ready,
    output logic    dist_valid,
    output node_t   dist_node,
    output dist_t   dist_value,
    output logic    dist_last,
    output logic    load_en,
    output node_t   load_src,
    output node_t   load_dst,
    output weight_t load_weight,
    output logic    adj_clear,
    output node_t   rd_node,
    output slot_t   rd_slot,
    output logic    push,
    output dist_t   push_dist,
    output node_t   push_node,
    output logic    pop,
    output logic    heap_clear
);

    ctrl_state_t state;
    node_t       last_node;        // node_count - 1, a count of 0 wraps to 16 nodes
    logic [4:0]  edge_cnt;
    node_t       cur_node;
    dist_t       cur_dist;
    slot_t       slot;
    node_t       stream_node;
    dist_t       dist_tab [`MAX_NODES];
    logic        visited  [`MAX_NODES];

    logic        edge_fire;
    logic        job_start;
    logic        slot_ok;
    dist_t       cand;
    logic        relax_hit;

    assign edge_ready = (state == IDLE) || (state == LOAD);
    assign edge_fire  = edge_valid && edge_ready;
    assign job_start  = edge_fire && (state == IDLE);

    assign load_en     = edge_fire;
    assign load_src    = edge_src;
    assign load_dst    = edge_dst;
    assign load_weight = edge_weight;
    assign adj_clear   = job_start;
    assign heap_clear  = job_start;

    assign rd_node   = cur_node;
    assign rd_slot   = slot;
    assign slot_ok   = slot < rd_degree;
    assign cand      = cur_dist + dist_t'(rd_weight);
    assign relax_hit = slot_ok && !visited[rd_neighbor] && (dist_tab[rd_neighbor] > cand);

    assign push      = (state == INIT) || ((state == RELAX) && relax_hit);
    assign push_dist = (state == INIT) ? '0 : cand;   // source goes in at distance 0
    assign push_node = (state == INIT) ? '0 : rd_neighbor;
    assign pop       = (state == POP) && !busy && !empty;

    assign dist_valid = (state == STREAM);
    assign dist_node  = stream_node;
    assign dist_value = dist_tab[stream_node];
    assign dist_last  = (state == STREAM) && (stream_node == last_node);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state       <= IDLE;
            last_node   <= '0;
            edge_cnt    <= '0;
            slot        <= '0;
            stream_node <= '0;
        end else begin
            case (state)
                IDLE: if (job_start) begin
                    last_node <= node_count - 1'b1;
                    edge_cnt  <= 5'd1;
                    state     <= edge_last ? INIT : LOAD;
                end
                LOAD: if (edge_fire) begin
                    edge_cnt <= edge_cnt + 1'b1;
                    if (edge_last) state <= INIT;
                end
                INIT: state <= POP;
                POP: if (!busy) begin
                    if (empty) begin
                        stream_node <= '0;
                        state       <= STREAM;
                    end else begin
                        state <= WAIT_POP;
                    end
                end
                WAIT_POP: if (!busy) state <= CHECK;
                CHECK: begin
                    slot  <= '0;
                    state <= visited[cur_node] ? POP : RELAX;  // stale entry is dropped
                end
                RELAX: begin
                    if (!slot_ok) begin
                        state <= POP;
                    end else begin
                        slot <= slot + 1'b1;
                        if (relax_hit) state <= WAIT_PUSH;
                    end
                end
                WAIT_PUSH: if (!busy) state <= RELAX;
                STREAM: if (dist_ready) begin
                    if (dist_last) state <= IDLE;
                    else           stream_node <= stream_node + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // distance and visited tables, rebuilt in INIT for every job
    always_ff @(posedge clk) begin
        if (state == INIT) begin
            for (int i = 0; i < `MAX_NODES; i++) begin
                dist_tab[i] <= dist_t'(`DIST_INF);
                visited[i]  <= 1'b0;
            end
            dist_tab[0] <= '0;
        end
        if (state == POP && !busy && !empty) begin
            cur_node <= top_node;   // minimum is read before the heap reorders
            cur_dist <= top_dist;
        end
        if (state == CHECK) visited[cur_node] <= 1'b1;
        if (state == RELAX && relax_hit) dist_tab[rd_neighbor] <= cand;
    end

    a_edge_limit: assert property (@(posedge clk) disable iff (!reset)
        (edge_fire && state == LOAD) |-> edge_cnt < `MAX_EDGES)
        else $error("more than %0d edges in one job", `MAX_EDGES);

endmodule

// File: hdl/dijkstra_top.sv
`timescale 1ns/1ps

module dijkstra_top
    import dijkstra_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    edge_valid,
    input  node_t   node_count,
    input  node_t   edge_src,
    input  node_t   edge_dst,
    input  weight_t edge_weight,
    input  logic    edge_last,
    input  logic    dist_ready,
    output logic    edge_ready,
    output logic    dist_valid,
    output node_t   dist_node,
    output dist_t   dist_value,
    output logic    dist_last
);

    logic    load_en;
    node_t   load_src;
    node_t   load_dst;
    weight_t load_weight;
    logic    adj_clear;
    node_t   rd_node;
    slot_t   rd_slot;
    node_t   rd_neighbor;
    weight_t rd_weight;
    slot_t   rd_degree;

    logic    push;
    dist_t   push_dist;
    node_t   push_node;
    logic    pop;
    logic    heap_clear;
    dist_t   top_dist;
    node_t   top_node;
    logic    empty;
    logic    busy;

    adjacency_list u_adjacency_list (
        .clk         (clk),
        .reset       (reset),
        .clear       (adj_clear),
        .load_en     (load_en),
        .load_src    (load_src),
        .load_dst    (load_dst),
        .load_weight (load_weight),
        .rd_node     (rd_node),
        .rd_slot     (rd_slot),
        .rd_neighbor (rd_neighbor),
        .rd_weight   (rd_weight),
        .rd_degree   (rd_degree)
    );

    min_heap u_min_heap (
        .clk       (clk),
        .reset     (reset),
        .clear     (heap_clear),
        .push      (push),
        .push_dist (push_dist),
        .push_node (push_node),
        .pop       (pop),
        .top_dist  (top_dist),
        .top_node  (top_node),
        .empty     (empty),
        .busy      (busy)
    );

    dijkstra_ctrl u_dijkstra_ctrl (
        .clk         (clk),
        .reset       (reset),
        .edge_valid  (edge_valid),
        .node_count  (node_count),
        .edge_src    (edge_src),
        .edge_dst    (edge_dst),
        .edge_weight (edge_weight),
        .edge_last   (edge_last),
        .dist_ready  (dist_ready),
        .rd_neighbor (rd_neighbor),
        .rd_weight   (rd_weight),
        .rd_degree   (rd_degree),
        .top_dist    (top_dist),
        .top_node    (top_node),
        .empty       (empty),
        .busy        (busy),
        .edge_ready  (edge_ready),
        .dist_valid  (dist_valid),
        .dist_node   (dist_node),
        .dist_value  (dist_value),
        .dist_last   (dist_last),
        .load_en     (load_en),
        .load_src    (load_src),
        .load_dst    (load_dst),
        .load_weight (load_weight),
        .adj_clear   (adj_clear),
        .rd_node     (rd_node),
        .rd_slot     (rd_slot),
        .push        (push),
        .push_dist   (push_dist),
        .push_node   (push_node),
        .pop         (pop),
        .heap_clear  (heap_clear)
    );

endmodule

// File: sim/dijkstra_checker.sv
`timescale 1ns/1ps
`include "dijkstra_consts.svh"

module dijkstra_checker
    import dijkstra_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  edge_valid,
    input  logic  edge_ready,
    input  logic  edge_last,
    input  logic  dist_valid,
    input  logic  dist_ready,
    input  node_t dist_node,
    input  dist_t dist_value,
    input  logic  dist_last,
    output int    beat_count,
    output int    error_total,
    output int    pass_count,
    output int    fail_count
);

    dist_t exp_dist [`MAX_NODES];
    string test_name;
    int    node_total;
    int    test_errors;
    logic  active;
    logic  was_in_reset;
    logic  loading;            // edges of a job still coming
    logic  last_edge_seen;     // edge_last transfer on the previous edge
    logic  last_beat_seen;
    logic  held;               // beat stalled on the previous edge
    node_t held_node;
    dist_t held_value;
    logic  held_last;

    initial begin
        beat_count  = 0;
        error_total = 0;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        node_total  = 0;
        active      = 1'b0;
        test_name   = "none";
    end

    task automatic begin_test(input string name, input int nodes);
        test_name   = name;
        node_total  = nodes;
        beat_count  = 0;
        test_errors = 0;
        active      = 1'b1;
    endtask

    task automatic set_expected(input int node, input int value);
        exp_dist[node] = dist_t'(value);
    endtask

    task automatic compare(input string sig, input int expected, input int actual);
        if (expected != actual) begin
            $display("[ERROR] t=%0d ns %s: expected %0d, actual %0d",
                     $time, sig, expected, actual);
            test_errors++;
            error_total++;
        end
    endtask

    task automatic protocol_error(input string what);
        $display("error at t=%0d ns in test %s: %s", $time, test_name, what);
        test_errors++;
        error_total++;
    endtask

    task automatic report_missing();
        $display("timeout in test %s: result beat %0d of %0d never arrived",
                 test_name, beat_count, node_total);
        test_errors++;
        error_total++;
    endtask

    task automatic end_test();
        active = 1'b0;
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: passed, %0d beats", test_name, beat_count);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic report_counts();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_count, fail_count, error_total);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            was_in_reset   = 1'b1;
            loading        = 1'b0;
            last_edge_seen = 1'b0;
            last_beat_seen = 1'b0;
            held           = 1'b0;
        end else begin
            if (was_in_reset) begin
                compare("edge_ready", 1, edge_ready);
                compare("dist_valid", 0, dist_valid);
                was_in_reset = 1'b0;
            end
            if (loading) compare("edge_ready", 1, edge_ready);         // one edge per cycle
            if (last_edge_seen) compare("edge_ready", 0, edge_ready);  // compute has begun
            if (last_beat_seen) compare("edge_ready", 1, edge_ready);  // back to idle
            if (held) begin
                compare("dist_valid", 1, dist_valid);
                compare("dist_node", held_node, dist_node);
                compare("dist_value", held_value, dist_value);
                compare("dist_last", held_last, dist_last);
            end
            if (edge_valid && edge_ready) loading = !edge_last;
            last_edge_seen = edge_valid && edge_ready && edge_last;
            last_beat_seen = dist_valid && dist_ready && dist_last;
            held           = dist_valid && !dist_ready;
            held_node      = dist_node;
            held_value     = dist_value;
            held_last      = dist_last;
            if (dist_valid && dist_ready) begin
                if (!active || beat_count >= node_total) begin
                    protocol_error("result beat outside the expected range");
                end else begin
                    compare("dist_node", beat_count, dist_node);
                    compare("dist_value", exp_dist[beat_count], dist_value);
                    compare("dist_last", beat_count == node_total - 1, dist_last);
                    beat_count++;
                end
            end
        end
    end

endmodule

// File: sim/tb_dijkstra.sv
`timescale 1ns/1ps
`include "dijkstra_consts.svh"

module tb_dijkstra
    import dijkstra_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic    clk;
    logic    reset;
    logic    edge_valid;
    node_t   node_count;
    node_t   edge_src;
    node_t   edge_dst;
    weight_t edge_weight;
    logic    edge_last;
    logic    dist_ready;
    logic    edge_ready;
    logic    dist_valid;
    node_t   dist_node;
    dist_t   dist_value;
    logic    dist_last;

    int      beat_count;
    int      error_total;
    int      pass_count;
    int      fail_count;

    integer  seed;
    integer  fd;
    logic    random_ready;     // back-pressure on for the running test
    logic    timed_out;
    logic    stim_error;

    dijkstra_top u_dijkstra_top (
        .clk         (clk),
        .reset       (reset),
        .edge_valid  (edge_valid),
        .node_count  (node_count),
        .edge_src    (edge_src),
        .edge_dst    (edge_dst),
        .edge_weight (edge_weight),
        .edge_last   (edge_last),
        .dist_ready  (dist_ready),
        .edge_ready  (edge_ready),
        .dist_valid  (dist_valid),
        .dist_node   (dist_node),
        .dist_value  (dist_value),
        .dist_last   (dist_last)
    );

    dijkstra_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .edge_valid  (edge_valid),
        .edge_ready  (edge_ready),
        .edge_last   (edge_last),
        .dist_valid  (dist_valid),
        .dist_ready  (dist_ready),
        .dist_node   (dist_node),
        .dist_value  (dist_value),
        .dist_last   (dist_last),
        .beat_count  (beat_count),
        .error_total (error_total),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        #1;
        if (random_ready) dist_ready = ($random(seed) & 32'd1) != 0;
        else              dist_ready = 1'b1;
    end

    task automatic next_cycle();   // to the drive point 1 ns after the rising edge
        @(posedge clk);
        #1;
    endtask

    // returns zero at end of file and skips comment lines
    task automatic read_tag(output logic [8*16-1:0] tag);
        logic [8*200-1:0] rest;
        int               code;
        tag  = '0;
        code = $fscanf(fd, "%s", tag);
        while (code == 1 && tag == "#") begin
            code = $fgets(rest, fd);
            code = $fscanf(fd, "%s", tag);
        end
        if (code != 1) tag = '0;
    endtask

    task automatic send_edge(input int src, input int dst, input int wt,
                             input logic last, input int nodes);
        int cycles;
        cycles      = 0;
        edge_valid  = 1'b1;
        node_count  = node_t'(nodes);   // 16 nodes go in as 0
        edge_src    = node_t'(src);
        edge_dst    = node_t'(dst);
        edge_weight = weight_t'(wt);
        edge_last   = last;
        while (!edge_ready && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!edge_ready) begin
            u_checker.protocol_error($sformatf("edge_ready stayed low for %0d cycles", TIMEOUT));
            timed_out = 1'b1;
        end else begin
            next_cycle();
        end
        edge_valid = 1'b0;
        edge_last  = 1'b0;
    endtask

    task automatic wait_results(input int nodes);
        int cycles;
        int seen;
        cycles = 0;
        seen   = beat_count;
        while (beat_count < nodes && cycles < TIMEOUT) begin
            next_cycle();
            if (beat_count != seen) begin
                seen   = beat_count;
                cycles = 0;
            end else begin
                cycles++;
            end
        end
        if (beat_count < nodes) begin
            u_checker.report_missing();
            timed_out = 1'b1;
        end else begin
            next_cycle();   // checker looks at edge_ready after the last beat
        end
    endtask

    initial begin
        logic [8*16-1:0] tag;
        logic [8*24-1:0] name_buf;
        int              code;
        int              nodes;
        int              edge_total;
        int              mode;
        int              value;
        int              src_list [`MAX_EDGES];
        int              dst_list [`MAX_EDGES];
        int              wt_list  [`MAX_EDGES];

        reset        = 1'b0;
        edge_valid   = 1'b0;
        node_count   = '0;
        edge_src     = '0;
        edge_dst     = '0;
        edge_weight  = '0;
        edge_last    = 1'b0;
        dist_ready   = 1'b0;
        seed         = 23284;
        random_ready = 1'b0;
        timed_out    = 1'b0;
        stim_error   = 1'b0;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b1;

        fd = $fopen("sim/dijkstra_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            stim_error = 1'b1;
        end
        while (fd != 0 && !timed_out && !stim_error) begin
            read_tag(tag);
            if (tag == '0) break;
            code = $fscanf(fd, "%s %d %d %d", name_buf, nodes, edge_total, mode);
            if (tag != "G" || code != 4 || nodes < 1 || nodes > `MAX_NODES
                || edge_total < 1 || edge_total > `MAX_EDGES) begin
                stim_error = 1'b1;
            end else begin
                for (int i = 0; i < edge_total; i++) begin
                    read_tag(tag);
                    code = $fscanf(fd, "%d %d %d", src_list[i], dst_list[i], wt_list[i]);
                    if (tag != "E" || code != 3) stim_error = 1'b1;
                end
                read_tag(tag);
                if (tag != "X") stim_error = 1'b1;
                u_checker.begin_test($sformatf("%0s", name_buf), nodes);
                for (int i = 0; i < nodes; i++) begin
                    code = $fscanf(fd, "%d", value);
                    if (code != 1) stim_error = 1'b1;
                    u_checker.set_expected(i, value);
                end
            end
            if (stim_error) begin
                $display("stimulus file is malformed near test %0s", name_buf);
                break;
            end
            random_ready = (mode != 0);
            for (int i = 0; i < edge_total && !timed_out; i++) begin
                send_edge(src_list[i], dst_list[i], wt_list[i], i == edge_total - 1, nodes);
            end
            if (!timed_out) wait_results(nodes);
            u_checker.end_test();
        end
        if (fd != 0) $fclose(fd);

        u_checker.report_counts();
        if (timed_out || stim_error || error_total != 0 || fail_count != 0 || pass_count == 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

// File: sim/dijkstra_stimulus.txt
# G name node_count edge_count random_ready (1 turns on dist_ready back-pressure)
# E src dst weight, one undirected edge
# X expected distances from node 0 upward, 255 when unreachable
# chain, distance is the running weight sum
G chain 5 4 0
E 0 1 3
E 1 2 5
E 2 3 2
E 3 4 7
X 0 3 8 10 17
# heavy direct edge 0-3 loses to the three-hop path
G shortcut 4 4 0
E 0 3 15
E 0 1 2
E 1 2 3
E 2 3 4
X 0 2 5 9
# nodes 2 to 5 have no path to node 0
G unreachable 6 3 1
E 0 1 4
E 2 3 1
E 3 4 2
X 0 4 255 255 255 255
# ring of 16 plus 8 chords
G dense 16 24 1
E 0 1 4
E 1 2 7
E 2 3 1
E 3 4 9
E 4 5 3
E 5 6 6
E 6 7 2
E 7 8 8
E 8 9 5
E 9 10 1
E 10 11 4
E 11 12 3
E 12 13 6
E 13 14 2
E 14 15 5
E 15 0 9
E 0 8 12
E 1 5 3
E 2 10 9
E 3 13 4
E 4 12 8
E 6 14 7
E 7 11 5
E 9 15 6
X 0 4 11 12 10 7 13 15 12 15 16 20 18 16 14 9
# back to back, the second job must not see the first job's edges
G back_a 8 7 0
E 0 1 1
E 1 2 1
E 2 3 1
E 3 4 1
E 4 5 1
E 5 6 1
E 6 7 1
X 0 1 2 3 4 5 6 7
G back_b 3 1 1
E 0 2 6
X 0 255 6

// File: flist.f
+incdir+hdl
hdl/dijkstra_pkg.sv
hdl/adjacency_list.sv
hdl/min_heap.sv
hdl/dijkstra_ctrl.sv
hdl/dijkstra_top.sv
sim/dijkstra_checker.sv
sim/tb_dijkstra.sv

// File: run_sim.sh
#!/bin/sh
# run from the project root

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_dijkstra \
    -o tb_dijkstra > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_dijkstra > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
